//--- arcade_board_io.f
hw/arcade_io_pkg.sv
hw/control_mapper.sv
hw/core_reset_ctrl.sv
hw/video_output_stage.sv
hw/sigma_delta_dac.sv
hw/arcade_board_io.sv
verification/board_io_checker.sv
verification/arcade_board_io_tb.sv

//--- hw/arcade_board_io.sv
// Arcade board I/O top level that joins controls, reset, video output and audio DAC
`timescale 1ns/10ps

module arcade_board_io #(
	parameter int RESET_HOLD = 16,
	parameter int PIX_DIV    = 4,
	parameter int DAC_BITS   = 10
) (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  arcade_io_pkg::cfg_status_t  status_i,
	input  logic [1:0]                  buttons_i,
	input  logic                        pll_locked_i,
	input  arcade_io_pkg::kbd_joy_t     kbd_joy_i,
	input  arcade_io_pkg::joy_t         joy0_i,
	input  arcade_io_pkg::joy_t         joy1_i,
	input  arcade_io_pkg::rgb3_t        core_rgb_i,
	input  logic                        hblank_i,
	input  logic                        vblank_i,
	input  logic                        hsync_i,
	input  logic                        vsync_i,
	input  logic [DAC_BITS-1:0]         audio_i,
	output arcade_io_pkg::player_ctrl_t player_ctrl_o,
	output logic                        core_reset_o,
	output logic                        pix_ce_o,
	output arcade_io_pkg::rgb6_t        vga_rgb_o,
	output logic                        vga_hs_o,
	output logic                        vga_vs_o,
	output logic                        audio_l_o,
	output logic                        audio_r_o
);

	logic dac_bit;

	// ======================================================================
	// Player controls
	// ======================================================================

	control_mapper control_mapper_i (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.rotated_i     (status_i.rotated),
		.kbd_joy_i     (kbd_joy_i),
		.joy0_i        (joy0_i),
		.joy1_i        (joy1_i),
		.player_ctrl_o (player_ctrl_o)
	);

	// ======================================================================
	// Core reset
	// ======================================================================

	core_reset_ctrl #(
		.RESET_HOLD (RESET_HOLD)
	) core_reset_ctrl_i (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.menu_reset_i   (status_i.menu_reset),
		.toggle_reset_i (status_i.reset_toggle),
		.buttons_i      (buttons_i),
		.pll_locked_i   (pll_locked_i),
		.core_reset_o   (core_reset_o)
	);

	// ======================================================================
	// Video and audio
	// ======================================================================

	video_output_stage #(
		.PIX_DIV (PIX_DIV)
	) video_output_stage_i (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.scan_mode_i (status_i.scan_mode),
		.rgb_i       (core_rgb_i),
		.hblank_i    (hblank_i),
		.vblank_i    (vblank_i),
		.hsync_i     (hsync_i),
		.vsync_i     (vsync_i),
		.pix_ce_o    (pix_ce_o),
		.rgb_o       (vga_rgb_o),
		.hs_o        (vga_hs_o),
		.vs_o        (vga_vs_o)
	);

	sigma_delta_dac #(
		.DAC_BITS (DAC_BITS)
	) sigma_delta_dac_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.sample_i (audio_i),
		.dac_o    (dac_bit)
	);

	// The core's sound is mono, both channels carry the same stream
	assign audio_l_o = dac_bit;
	assign audio_r_o = dac_bit;

endmodule

//--- hw/arcade_io_pkg.sv
// Shared type definitions for the arcade board I/O subsystem
package arcade_io_pkg;

	// ======================================================================
	// Player inputs
	// ======================================================================

	// One digital joystick as delivered by the configuration link
	typedef struct packed {
		logic [2:0] spare;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Joystick word decoded from the PS/2 keyboard
	typedef struct packed {
		logic [1:0] spare;
		logic       down;
		logic       up;
		logic       left;
		logic       right;
		logic       coin;
		logic       start2;
		logic       start1;
		logic       fire;
	} kbd_joy_t;

	// Control bits handed to the game core
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} player_ctrl_t;

	// ======================================================================
	// Configuration and video
	// ======================================================================

	// Encoding follows the order of the scandoubler menu entry
	typedef enum logic [1:0] {
		SCAN_NONE  = 2'd0,
		SCAN_HQ2X  = 2'd1,
		SCAN_CRT25 = 2'd2,
		SCAN_CRT50 = 2'd3
	} scan_mode_e;

	typedef struct packed {
		logic [24:0] spare_hi;
		logic        reset_toggle;
		logic        spare_5;
		scan_mode_e  scan_mode;
		logic        rotated;
		logic        spare_1;
		logic        menu_reset;
	} cfg_status_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb3_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb6_t;

endpackage

//--- hw/control_mapper.sv
// Control mapper that merges keyboard and joystick inputs into registered player controls
`timescale 1ns/10ps

module control_mapper (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        rotated_i,
	input  arcade_io_pkg::kbd_joy_t     kbd_joy_i,
	input  arcade_io_pkg::joy_t         joy0_i,
	input  arcade_io_pkg::joy_t         joy1_i,
	output arcade_io_pkg::player_ctrl_t player_ctrl_o
);

	// Each direction seen from any of the three sources
	logic any_up;
	logic any_down;
	logic any_left;
	logic any_right;
	logic any_fire;

	arcade_io_pkg::player_ctrl_t ctrl_next;
	arcade_io_pkg::player_ctrl_t ctrl_q;

	assign any_up    = kbd_joy_i.up    | joy0_i.up    | joy1_i.up;
	assign any_down  = kbd_joy_i.down  | joy0_i.down  | joy1_i.down;
	assign any_left  = kbd_joy_i.left  | joy0_i.left  | joy1_i.left;
	assign any_right = kbd_joy_i.right | joy0_i.right | joy1_i.right;
	assign any_fire  = kbd_joy_i.fire  | joy0_i.fire  | joy1_i.fire;

	// ======================================================================
	// Orientation
	// ======================================================================

	always_comb begin
		ctrl_next = '0;
		if (rotated_i) begin
			// Monitor turned a quarter turn, so the stick is remapped to match
			ctrl_next.up    = any_right;
			ctrl_next.down  = any_left;
			ctrl_next.left  = any_up;
			ctrl_next.right = any_down;
		end else begin
			ctrl_next.up    = any_up;
			ctrl_next.down  = any_down;
			ctrl_next.left  = any_left;
			ctrl_next.right = any_right;
		end

		ctrl_next.fire = any_fire;

		// Start and coin only exist on the keyboard
		ctrl_next.start1 = kbd_joy_i.start1;
		ctrl_next.start2 = kbd_joy_i.start2;
		ctrl_next.coin   = kbd_joy_i.coin;
	end

	// ======================================================================
	// Output register
	// ======================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0;
		end else begin
			ctrl_q <= ctrl_next;
		end
	end

	assign player_ctrl_o = ctrl_q;

endmodule

//--- hw/core_reset_ctrl.sv
// Core reset controller that combines all reset requests into one stretched reset
`timescale 1ns/10ps

module core_reset_ctrl #(
	parameter int RESET_HOLD = 16
) (
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  logic       menu_reset_i,
	input  logic       toggle_reset_i,
	input  logic [1:0] buttons_i,
	input  logic       pll_locked_i,
	output logic       core_reset_o
);

	localparam int CNT_W = (RESET_HOLD > 0) ? $clog2(RESET_HOLD + 1) : 1;

	logic             reset_req;
	logic             req_meta;
	logic             req_sync;
	logic [CNT_W-1:0] hold_cnt;

	// Button 0 is left to the core, only button 1 acts as a reset
	assign reset_req = menu_reset_i | toggle_reset_i | buttons_i[1] | ~pll_locked_i;

	// Requests come from other domains and from the PLL, so two flops first.
	// Both start high so the core stays in reset straight out of power up
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			req_meta <= 1'b1;
			req_sync <= 1'b1;
		end else begin
			req_meta <= reset_req;
			req_sync <= req_meta;
		end
	end

	// ======================================================================
	// Hold counter
	// ======================================================================

	// Reloaded as long as a request is seen, then counts down to zero
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hold_cnt <= CNT_W'(RESET_HOLD);
		end else if (req_sync) begin
			hold_cnt <= CNT_W'(RESET_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// The core stays in reset until the hold count has run out
	assign core_reset_o = (hold_cnt != '0);

endmodule

//--- hw/sigma_delta_dac.sv
// First-order sigma-delta modulator that turns audio samples into a one-bit stream
`timescale 1ns/10ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 10
) (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  logic [DAC_BITS-1:0] sample_i,
	output logic                dac_o
);

	// The sum is one bit wider than the sample, its top bit is the carry
	logic [DAC_BITS:0]   sum;
	logic [DAC_BITS-1:0] err_q;
	logic                dac_q;

	// ======================================================================
	// Error feedback accumulator
	// ======================================================================

	// Whatever does not overflow is kept as the quantization error and added
	// back on the next cycle. Over 2^DAC_BITS cycles of a constant sample the
	// accumulator returns to its start value, so the number of carries in that
	// window equals the sample exactly
	assign sum = {1'b0, err_q} + {1'b0, sample_i};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			err_q <= '0;
			dac_q <= 1'b0;
		end else begin
			err_q <= sum[DAC_BITS-1:0];
			dac_q <= sum[DAC_BITS];
		end
	end

	// Registered so the pin sees a clean edge each cycle
	assign dac_o = dac_q;

endmodule

//--- hw/video_output_stage.sv
// Video output stage that makes the pixel enable and expands, blanks and dims colour
`timescale 1ns/10ps

module video_output_stage #(
	parameter int PIX_DIV = 4
) (
	input  logic                      clk_i,
	input  logic                      arst_n_i,
	input  arcade_io_pkg::scan_mode_e scan_mode_i,
	input  arcade_io_pkg::rgb3_t      rgb_i,
	input  logic                      hblank_i,
	input  logic                      vblank_i,
	input  logic                      hsync_i,
	input  logic                      vsync_i,
	output logic                      pix_ce_o,
	output arcade_io_pkg::rgb6_t      rgb_o,
	output logic                      hs_o,
	output logic                      vs_o
);

	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

	logic [DIV_W-1:0]     div_cnt;
	logic                 pix_ce_q;
	logic                 blank;
	logic                 line_odd_q;
	arcade_io_pkg::rgb6_t rgb_q;
	logic                 hs_q;
	logic                 vs_q;

	// Widen one channel, blank it and apply the scanline effect on odd lines
	function automatic logic [5:0] shade(input logic [2:0] c3, input logic blank_in,
			input logic odd, input arcade_io_pkg::scan_mode_e mode);
		logic [5:0] c6;
		c6 = blank_in ? 6'd0 : {c3, c3};
		if (odd) begin
			case (mode)
				arcade_io_pkg::SCAN_CRT50: c6 = c6 >> 1;
				arcade_io_pkg::SCAN_CRT25: c6 = c6 - (c6 >> 2);
				default: c6 = c6;
			endcase
		end
		return c6;
	endfunction

	// ======================================================================
	// Pixel enable
	// ======================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_cnt  <= '0;
			pix_ce_q <= 1'b0;
		end else begin
			div_cnt  <= (div_cnt == DIV_W'(PIX_DIV - 1)) ? '0 : div_cnt + 1'b1;
			pix_ce_q <= (div_cnt == DIV_W'(PIX_DIV - 1));
		end
	end

	assign pix_ce_o = pix_ce_q;
	assign blank    = hblank_i | vblank_i;

	// ======================================================================
	// Colour and sync registers
	// ======================================================================

	// hs_q and vs_q hold the previous sample, which gives the sync edges.
	// Dimming uses the line parity as it stands before this pixel's edge
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rgb_q      <= '0;
			hs_q       <= 1'b1;
			vs_q       <= 1'b1;
			line_odd_q <= 1'b0;
		end else if (pix_ce_q) begin
			rgb_q.r <= shade(rgb_i.r, blank, line_odd_q, scan_mode_i);
			rgb_q.g <= shade(rgb_i.g, blank, line_odd_q, scan_mode_i);
			rgb_q.b <= shade(rgb_i.b, blank, line_odd_q, scan_mode_i);
			hs_q    <= hsync_i;
			vs_q    <= vsync_i;
			if (vsync_i && !vs_q) begin
				line_odd_q <= 1'b0;
			end else if (hsync_i && !hs_q) begin
				line_odd_q <= ~line_odd_q;
			end
		end
	end

	assign rgb_o = rgb_q;
	assign hs_o  = hs_q;
	assign vs_o  = vs_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the board I/O testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal \
	-f arcade_board_io.f \
	--top-module arcade_board_io_tb \
	-o arcade_board_io_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/arcade_board_io_sim); then
	echo "$sim_out"
	echo "Simulation run returned an error status"
	exit 1
fi

echo "$sim_out"

if echo "$sim_out" | grep -q "Verification passed"; then
	exit 0
fi

exit 1

//--- verification/arcade_board_io_tb.sv
// Testbench for the arcade board I/O subsystem that applies a stimulus table in a loop
`timescale 1ns/10ps

module arcade_board_io_tb;

	localparam int RESET_HOLD = 16;
	localparam int PIX_DIV    = 4;
	localparam int DAC_BITS   = 10;
	localparam int K_CTRL     = 0;
	localparam int K_RESET    = 1;
	localparam int K_VIDEO    = 2;
	localparam int K_AUDIO    = 3;

	typedef struct {
		int                         test_num;
		int                         kind;
		arcade_io_pkg::cfg_status_t status;
		logic [1:0]                 buttons;
		logic                       pll;
		logic [DAC_BITS-1:0]        audio;
		int                         cycles;
	} row_t;

	logic                        clk_i;
	logic                        arst_n_i;
	arcade_io_pkg::cfg_status_t  status_i;
	logic [1:0]                  buttons_i;
	logic                        pll_locked_i;
	arcade_io_pkg::kbd_joy_t     kbd_joy_i;
	arcade_io_pkg::joy_t         joy0_i;
	arcade_io_pkg::joy_t         joy1_i;
	arcade_io_pkg::rgb3_t        core_rgb_i;
	logic                        hblank_i;
	logic                        vblank_i;
	logic                        hsync_i;
	logic                        vsync_i;
	logic [DAC_BITS-1:0]         audio_i;
	arcade_io_pkg::player_ctrl_t player_ctrl_o;
	logic                        core_reset_o;
	logic                        pix_ce_o;
	arcade_io_pkg::rgb6_t        vga_rgb_o;
	logic                        vga_hs_o;
	logic                        vga_vs_o;
	logic                        audio_l_o;
	logic                        audio_r_o;

	row_t        table_q[$];
	logic [31:0] lfsr_q;
	logic [31:0] rnd;
	int          cur_test;
	int          cur_kind;
	logic        test_end;
	logic        timed_out;
	int          pass_cnt;
	int          fail_cnt;
	int          reset_events;
	int          window_events;

	arcade_board_io #(
		.RESET_HOLD (RESET_HOLD),
		.PIX_DIV    (PIX_DIV),
		.DAC_BITS   (DAC_BITS)
	) arcade_board_io_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .status_i(status_i), .buttons_i(buttons_i),
		.pll_locked_i(pll_locked_i), .kbd_joy_i(kbd_joy_i), .joy0_i(joy0_i),
		.joy1_i(joy1_i), .core_rgb_i(core_rgb_i), .hblank_i(hblank_i),
		.vblank_i(vblank_i), .hsync_i(hsync_i), .vsync_i(vsync_i), .audio_i(audio_i),
		.player_ctrl_o(player_ctrl_o), .core_reset_o(core_reset_o), .pix_ce_o(pix_ce_o),
		.vga_rgb_o(vga_rgb_o), .vga_hs_o(vga_hs_o), .vga_vs_o(vga_vs_o),
		.audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
	);

	board_io_checker #(
		.RESET_HOLD (RESET_HOLD),
		.PIX_DIV    (PIX_DIV),
		.DAC_BITS   (DAC_BITS)
	) board_io_checker_i (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .status_i(status_i), .buttons_i(buttons_i),
		.pll_locked_i(pll_locked_i), .kbd_joy_i(kbd_joy_i), .joy0_i(joy0_i),
		.joy1_i(joy1_i), .core_rgb_i(core_rgb_i), .hblank_i(hblank_i),
		.vblank_i(vblank_i), .hsync_i(hsync_i), .vsync_i(vsync_i), .audio_i(audio_i),
		.player_ctrl_o(player_ctrl_o), .core_reset_o(core_reset_o), .pix_ce_o(pix_ce_o),
		.vga_rgb_o(vga_rgb_o), .vga_hs_o(vga_hs_o), .vga_vs_o(vga_vs_o),
		.audio_l_o(audio_l_o), .audio_r_o(audio_r_o), .test_num_i(cur_test),
		.kind_i(cur_kind), .test_end_i(test_end), .pass_cnt_o(pass_cnt),
		.fail_cnt_o(fail_cnt), .reset_events_o(reset_events),
		.window_events_o(window_events)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per random bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	task automatic add_row(input int kind, input logic menu, input logic toggle,
			input logic rot, input arcade_io_pkg::scan_mode_e scan, input logic [1:0] btn,
			input logic pll, input logic [DAC_BITS-1:0] audio, input int cycles);
		row_t r;
		r.test_num            = table_q.size() + 1;
		r.kind                = kind;
		r.status              = '0;
		r.status.menu_reset   = menu;
		r.status.reset_toggle = toggle;
		r.status.rotated      = rot;
		r.status.scan_mode    = scan;
		r.buttons             = btn;
		r.pll                 = pll;
		r.audio               = audio;
		r.cycles              = cycles;
		table_q.push_back(r);
	endtask

	task automatic next_edge();
		@(posedge clk_i);
		#1;
	endtask

	task automatic idle_inputs();
		status_i     = '0;
		buttons_i    = 2'b00;
		pll_locked_i = 1'b1;
		kbd_joy_i    = '0;
		joy0_i       = '0;
		joy1_i       = '0;
		core_rgb_i   = '0;
		hblank_i     = 1'b0;
		vblank_i     = 1'b0;
		hsync_i      = 1'b0;
		vsync_i      = 1'b0;
	endtask

	task automatic wait_pix_ce();
		int n;
		n = 0;
		do begin
			next_edge();
			n++;
		end while (!pix_ce_o && n < 4 * PIX_DIV);
		if (!pix_ce_o) begin
			$display("Timed out waiting for a pixel enable pulse in test %0d", cur_test);
			timed_out = 1'b1;
		end
	endtask

	// Waits until the checker reports a reset fall or a finished audio window
	task automatic wait_event(input logic audio_evt, input int start, input int limit);
		int n;
		n = 0;
		while ((audio_evt ? window_events : reset_events) == start && n < limit) begin
			next_edge();
			n++;
		end
		if ((audio_evt ? window_events : reset_events) == start) begin
			$display("Timed out waiting for the checker in test %0d", cur_test);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_row(input row_t r);
		int start;
		cur_test = r.test_num;
		cur_kind = r.kind;
		status_i = r.status;
		case (r.kind)
			K_CTRL: begin
				for (int i = 0; i < r.cycles; i++) begin
					rnd       = take_bits(10);
					kbd_joy_i = rnd[9:0];
					rnd       = take_bits(8);
					joy0_i    = rnd[7:0];
					rnd       = take_bits(8);
					joy1_i    = rnd[7:0];
					next_edge();
				end
				idle_inputs();
				repeat (2) next_edge();
			end
			K_RESET: begin
				start        = reset_events;
				buttons_i    = r.buttons;
				pll_locked_i = r.pll;
				repeat (r.cycles) next_edge();
				idle_inputs();
				wait_event(1'b0, start, 8 * RESET_HOLD);
			end
			K_VIDEO: begin
				// Vblank covers the first two pixels and vsync at pixel 1 clears parity.
				// Every fourth pixel starts a line
				for (int p = 0; p < r.cycles && !timed_out; p++) begin
					wait_pix_ce();
					rnd        = take_bits(9);
					core_rgb_i = rnd[8:0];
					hblank_i   = (take_bits(3) == 32'd0);
					vblank_i   = (p < 2);
					hsync_i    = (p % 4 == 3);
					vsync_i    = (p == 1);
				end
				if (!timed_out) begin
					wait_pix_ce();
				end
				idle_inputs();
				repeat (2) next_edge();
			end
			default: begin
				start   = window_events;
				audio_i = r.audio;
				wait_event(1'b1, start, 4 << DAC_BITS);
			end
		endcase
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		arst_n_i  = 1'b0;
		idle_inputs();
		audio_i   = '0;
		lfsr_q    = 32'ha0bfc539;
		cur_test  = 0;
		cur_kind  = K_CTRL;
		test_end  = 1'b0;
		timed_out = 1'b0;

		add_row(K_CTRL, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 0, 40);
		add_row(K_CTRL, 0, 0, 1, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 0, 40);
		add_row(K_RESET, 1, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 0, 10);
		add_row(K_RESET, 0, 1, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 0, 10);
		add_row(K_RESET, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b10, 1, 0, 10);
		add_row(K_RESET, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 0, 0, 64);
		add_row(K_VIDEO, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 0, 40);
		add_row(K_VIDEO, 0, 0, 0, arcade_io_pkg::SCAN_CRT50, 2'b00, 1, 0, 40);
		add_row(K_VIDEO, 0, 0, 0, arcade_io_pkg::SCAN_CRT25, 2'b00, 1, 0, 40);
		add_row(K_AUDIO, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 10'd0, 0);
		add_row(K_AUDIO, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 10'd1, 0);
		add_row(K_AUDIO, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 10'd512, 0);
		add_row(K_AUDIO, 0, 0, 0, arcade_io_pkg::SCAN_NONE, 2'b00, 1, 10'd1023, 0);

		repeat (16) @(posedge clk_i);
		#1;
		arst_n_i = 1'b1;

		// The core reset drops on its own once the synchronizer has cleared
		for (int n = 0; n < 8 * RESET_HOLD && core_reset_o; n++) begin
			next_edge();
		end
		if (core_reset_o) begin
			$display("Core reset never released after board reset");
			timed_out = 1'b1;
		end

		for (int i = 0; i < table_q.size() && !timed_out; i++) begin
			run_row(table_q[i]);
			if (!timed_out) begin
				test_end = 1'b1;
				next_edge();
				test_end = 1'b0;
			end
		end

		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (timed_out || fail_cnt != 0 || pass_cnt != table_q.size()) begin
			$display("Verification failed");
		end else begin
			$display("Verification passed");
		end
		$finish;
	end

endmodule

//--- verification/board_io_checker.sv
// Board I/O checker that models the subsystem rules and compares every DUT output
`timescale 1ns/10ps

module board_io_checker #(
	parameter int RESET_HOLD = 16,
	parameter int PIX_DIV    = 4,
	parameter int DAC_BITS   = 10
) (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  arcade_io_pkg::cfg_status_t  status_i,
	input  logic [1:0]                  buttons_i,
	input  logic                        pll_locked_i,
	input  arcade_io_pkg::kbd_joy_t     kbd_joy_i,
	input  arcade_io_pkg::joy_t         joy0_i,
	input  arcade_io_pkg::joy_t         joy1_i,
	input  arcade_io_pkg::rgb3_t        core_rgb_i,
	input  logic                        hblank_i,
	input  logic                        vblank_i,
	input  logic                        hsync_i,
	input  logic                        vsync_i,
	input  logic [DAC_BITS-1:0]         audio_i,
	input  arcade_io_pkg::player_ctrl_t player_ctrl_o,
	input  logic                        core_reset_o,
	input  logic                        pix_ce_o,
	input  arcade_io_pkg::rgb6_t        vga_rgb_o,
	input  logic                        vga_hs_o,
	input  logic                        vga_vs_o,
	input  logic                        audio_l_o,
	input  logic                        audio_r_o,
	input  int                          test_num_i,
	input  int                          kind_i,
	input  logic                        test_end_i,
	output int                          pass_cnt_o,
	output int                          fail_cnt_o,
	output int                          reset_events_o,
	output int                          window_events_o
);

	localparam int K_AUDIO = 3;

	int                          test_err = 0;
	int                          cyc = 0;
	int                          last_ce = 0;
	int                          req_run = 0;
	int                          rcnt = 0;
	int                          win = 0;
	int                          ones = 0;
	int                          last_test = 0;
	logic                        prev_valid;
	logic                        ce_seen;
	logic                        pend_video;
	logic                        m_odd;
	logic                        m_hs;
	logic                        m_vs;
	logic                        req;
	logic                        prev_req;
	logic                        counting;
	logic                        win_done;
	logic                        blank;
	logic [DAC_BITS-1:0]         last_audio;
	logic                        prev_rot;
	arcade_io_pkg::kbd_joy_t     prev_kbd;
	arcade_io_pkg::joy_t         prev_j0;
	arcade_io_pkg::joy_t         prev_j1;
	arcade_io_pkg::player_ctrl_t exp_ctrl;
	arcade_io_pkg::rgb6_t        exp_rgb;
	logic                        exp_hs;
	logic                        exp_vs;

	initial begin
		pass_cnt_o      = 0;
		fail_cnt_o      = 0;
		reset_events_o  = 0;
		window_events_o = 0;
	end

	// Directions are ORed over all sources, then turned a quarter when rotated
	function automatic arcade_io_pkg::player_ctrl_t expect_ctrl(
			input arcade_io_pkg::kbd_joy_t k, input arcade_io_pkg::joy_t a,
			input arcade_io_pkg::joy_t b, input logic rot);
		logic                        u;
		logic                        d;
		logic                        l;
		logic                        r;
		arcade_io_pkg::player_ctrl_t c;
		u = k.up | a.up | b.up;
		d = k.down | a.down | b.down;
		l = k.left | a.left | b.left;
		r = k.right | a.right | b.right;
		c.up     = rot ? r : u;
		c.down   = rot ? l : d;
		c.left   = rot ? u : l;
		c.right  = rot ? d : r;
		c.fire   = k.fire | a.fire | b.fire;
		c.start1 = k.start1;
		c.start2 = k.start2;
		c.coin   = k.coin;
		return c;
	endfunction

	// A 3-bit level repeated twice is the level times nine
	function automatic logic [5:0] expect_channel(input logic [2:0] c3, input logic blk,
			input logic odd, input arcade_io_pkg::scan_mode_e mode);
		int v;
		v = blk ? 0 : int'(c3) * 9;
		if (odd && mode == arcade_io_pkg::SCAN_CRT50) begin
			v = v / 2;
		end else if (odd && mode == arcade_io_pkg::SCAN_CRT25) begin
			v = v - v / 4;
		end
		return 6'(v);
	endfunction

	task automatic report_error(input string msg);
		$display("error %0t: test %0d: %s", $time, test_num_i, msg);
		test_err++;
	endtask

	// ======================================================================
	// Sampling on the falling edge, where inputs and outputs are settled
	// ======================================================================

	always @(negedge clk_i) begin
		if (!arst_n_i) begin
			prev_valid = 1'b0;
			ce_seen    = 1'b0;
			pend_video = 1'b0;
			m_odd      = 1'b0;
			m_hs       = 1'b1;
			m_vs       = 1'b1;
			req_run    = 0;
			prev_req   = 1'b0;
			counting   = 1'b0;
			win        = 0;
			win_done   = 1'b0;
		end else begin
			cyc++;
			if (audio_l_o !== audio_r_o) begin
				report_error("audio_r_o differs from audio_l_o");
			end

			// Controls seen now were captured from the previous sample
			if (prev_valid) begin
				exp_ctrl = expect_ctrl(prev_kbd, prev_j0, prev_j1, prev_rot);
				if (player_ctrl_o !== exp_ctrl) begin
					report_error($sformatf("player_ctrl_o %h, expected %h",
						player_ctrl_o, exp_ctrl));
				end
			end
			prev_kbd   = kbd_joy_i;
			prev_j0    = joy0_i;
			prev_j1    = joy1_i;
			prev_rot   = status_i.rotated;
			prev_valid = 1'b1;

			if (pend_video) begin
				if (vga_rgb_o !== exp_rgb || vga_hs_o !== exp_hs || vga_vs_o !== exp_vs) begin
					report_error($sformatf("video %h %b %b, expected %h %b %b",
						vga_rgb_o, vga_hs_o, vga_vs_o, exp_rgb, exp_hs, exp_vs));
				end
				pend_video = 1'b0;
			end

			if (pix_ce_o) begin
				if (ce_seen && cyc - last_ce != PIX_DIV) begin
					report_error($sformatf("pixel enable gap %0d cycles", cyc - last_ce));
				end
				ce_seen   = 1'b1;
				last_ce   = cyc;
				blank     = hblank_i | vblank_i;
				exp_rgb.r = expect_channel(core_rgb_i.r, blank, m_odd, status_i.scan_mode);
				exp_rgb.g = expect_channel(core_rgb_i.g, blank, m_odd, status_i.scan_mode);
				exp_rgb.b = expect_channel(core_rgb_i.b, blank, m_odd, status_i.scan_mode);
				exp_hs    = hsync_i;
				exp_vs    = vsync_i;
				if (vsync_i && !m_vs) begin
					m_odd = 1'b0;
				end else if (hsync_i && !m_hs) begin
					m_odd = !m_odd;
				end
				m_hs       = hsync_i;
				m_vs       = vsync_i;
				pend_video = 1'b1;
			end

			// Reset requests and the stretched release
			req = status_i.menu_reset | status_i.reset_toggle | buttons_i[1] | !pll_locked_i;
			if (req) begin
				req_run++;
				counting = 1'b0;
				if (req_run >= 4 && core_reset_o !== 1'b1) begin
					report_error("core_reset_o low while a reset request is present");
				end
			end else begin
				if (prev_req) begin
					counting = 1'b1;
					rcnt     = 0;
				end else if (counting) begin
					rcnt++;
					if (core_reset_o === 1'b0) begin
						counting = 1'b0;
						if (rcnt != RESET_HOLD + 2) begin
							report_error($sformatf("core reset fell after %0d cycles", rcnt));
						end
						reset_events_o++;
					end
				end
				req_run = 0;
			end
			prev_req = req;

			// Ones density over one full window of a constant sample
			if (kind_i != K_AUDIO || audio_i != last_audio || test_num_i != last_test) begin
				win      = 0;
				ones     = 0;
				win_done = 1'b0;
			end else if (!win_done) begin
				if (audio_l_o) begin
					ones++;
				end
				win++;
				if (win == (1 << DAC_BITS)) begin
					win_done = 1'b1;
					if (ones != int'(audio_i)) begin
						report_error($sformatf("%0d ones for sample %0d", ones, audio_i));
					end
					window_events_o++;
				end
			end
			last_audio = audio_i;
			last_test  = test_num_i;

			if (test_end_i) begin
				if (test_err == 0) begin
					pass_cnt_o++;
					$display("test %0d passed", test_num_i);
				end else begin
					fail_cnt_o++;
					$display("test %0d failed with %0d errors", test_num_i, test_err);
				end
				test_err = 0;
			end
		end
	end

endmodule
